// File: hw/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// byte address and pipeline word
`define DCACHE_ADDR_W 32
`define DCACHE_WORD_W 64

// set geometry, 64 sets of 32-byte lines
`define DCACHE_SETS 64
`define DCACHE_INDEX_W 6
`define DCACHE_OFFSET_W 5

// tag is what remains above index and offset
`define DCACHE_TAG_W 21

// a line is four 64-bit beats on the memory side
`define DCACHE_BEATS 4
`define DCACHE_LINE_W 256

`define DCACHE_WAYS 2

`endif

// File: hw/dcachePkg.sv
`include "dcache_params.svh"

package dcachePkg;

  typedef logic [`DCACHE_ADDR_W-1:0] addrT;
  typedef logic [`DCACHE_WORD_W-1:0] wordT;

  // one enable per byte lane
  typedef logic [`DCACHE_WORD_W/8-1:0] maskT;

  typedef logic [`DCACHE_TAG_W-1:0] tagT;
  typedef logic [`DCACHE_INDEX_W-1:0] indexT;

  // word within a line, address bits 4..3
  typedef logic [$clog2(`DCACHE_BEATS)-1:0] wordSelT;

  typedef logic [`DCACHE_LINE_W-1:0] lineT;
  typedef logic [$clog2(`DCACHE_WAYS)-1:0] wayT;

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    WriteBack,
    Refill,
    Fill
  } ctrlStateT;

endpackage

// File: hw/dcacheReqCapture.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcacheReqCapture (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               reqValid_i,
  input  logic               reqWrite_i,
  input  dcachePkg::addrT    reqAddr_i,
  input  dcachePkg::wordT    reqWrData_i,
  input  dcachePkg::maskT    reqWrMask_i,
  input  logic               idle_i,
  output logic               reqReady_o,
  output logic               accepted_o,
  output logic               isWrite_o,
  output dcachePkg::tagT     tag_o,
  output dcachePkg::indexT   index_o,
  output dcachePkg::wordSelT wordSel_o,
  output dcachePkg::wordT    wrData_o,
  output dcachePkg::maskT    wrMask_o
);

  // only one request in flight, so ready just follows the idle state
  assign reqReady_o = idle_i;
  assign accepted_o = reqValid_i && idle_i;

  // address fields feed the tag compare, keep them defined from reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      isWrite_o <= 1'b0;
      tag_o     <= '0;
      index_o   <= '0;
      wordSel_o <= '0;
    end else if (accepted_o) begin
      isWrite_o <= reqWrite_i;
      tag_o     <= reqAddr_i[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
      index_o   <= reqAddr_i[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
      wordSel_o <= reqAddr_i[`DCACHE_OFFSET_W-1 -: $bits(dcachePkg::wordSelT)];
    end
  end

  // store payload, already lane-aligned by the pipeline
  always_ff @(posedge clk) begin
    if (accepted_o) begin
      wrData_o <= reqWrData_i;
      wrMask_o <= reqWrMask_i;
    end
  end

endmodule

// File: hw/dcacheTagStore.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcacheTagStore (
  input  logic             clk,
  input  logic             rst_n,
  input  dcachePkg::indexT index_i,
  input  dcachePkg::tagT   tag_i,
  input  logic             missEn_i,
  input  logic             markDirty_i,
  input  logic             fillEn_i,
  output logic             hit_o,
  output dcachePkg::wayT   hitWay_o,
  output dcachePkg::wayT   victimWay_o,
  output logic             victimDirty_o,
  output dcachePkg::tagT   victimTag_o
);

  logic [`DCACHE_SETS-1:0] validQ [`DCACHE_WAYS];
  logic [`DCACHE_SETS-1:0] dirtyQ [`DCACHE_WAYS];
  dcachePkg::tagT          tagQ [`DCACHE_WAYS][`DCACHE_SETS];
  logic [`DCACHE_WAYS-1:0] wayHit;

  // replBitQ is the next victim, victimQ the way under replacement
  dcachePkg::wayT          replBitQ;
  dcachePkg::wayT          victimQ;

  always_comb begin
    hitWay_o = '0;
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      wayHit[w] = validQ[w][index_i] && (tagQ[w][index_i] == tag_i);
      if (wayHit[w]) begin
        hitWay_o = dcachePkg::wayT'(w);
      end
    end
  end

  assign hit_o = |wayHit;

  assign victimWay_o   = victimQ;
  assign victimDirty_o = validQ[victimQ][index_i] && dirtyQ[victimQ][index_i];
  assign victimTag_o   = tagQ[victimQ][index_i];

  // fill installs a clean line, a store hit marks it dirty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < `DCACHE_WAYS; w++) begin
        validQ[w] <= '0;
        dirtyQ[w] <= '0;
      end
    end else if (fillEn_i) begin
      validQ[victimQ][index_i] <= 1'b1;
      dirtyQ[victimQ][index_i] <= 1'b0;
    end else if (markDirty_i) begin
      dirtyQ[hitWay_o][index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagQ[victimQ][index_i] <= tag_i;
    end
  end

  // the bit flips on the miss, the victim pointer catches up after the fill
  // so the way stays fixed during write-back and refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      replBitQ <= '0;
      victimQ  <= '0;
    end else begin
      if (missEn_i) begin
        replBitQ <= ~replBitQ;
      end
      if (fillEn_i) begin
        victimQ <= replBitQ;
      end
    end
  end

  // a fill only follows a miss on the same tag, so no duplicate lines
  hitAtMostOneWay: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(wayHit));

  // controller only marks dirty on a store hit
  dirtyNeedsHit: assert property (@(posedge clk) disable iff (!rst_n)
    markDirty_i |-> hit_o);

endmodule

// File: hw/dcacheDataStore.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcacheDataStore (
  input  logic               clk,
  input  dcachePkg::indexT   index_i,
  input  dcachePkg::wordSelT wordSel_i,
  input  dcachePkg::wayT     hitWay_i,
  input  dcachePkg::wayT     victimWay_i,
  input  logic               storeEn_i,
  input  dcachePkg::wordT    wrData_i,
  input  dcachePkg::maskT    wrMask_i,
  input  logic               fillEn_i,
  input  dcachePkg::lineT    fillLine_i,
  output dcachePkg::wordT    rdWord_o,
  output dcachePkg::lineT    victimLine_o
);

  dcachePkg::lineT dataQ [`DCACHE_WAYS][`DCACHE_SETS];
  dcachePkg::lineT hitLine;
  dcachePkg::wordT bitMask;
  dcachePkg::wordT mergedWord;

  // combinational read, no latency to hide
  assign hitLine      = dataQ[hitWay_i][index_i];
  assign rdWord_o     = hitLine[wordSel_i * `DCACHE_WORD_W +: `DCACHE_WORD_W];
  assign victimLine_o = dataQ[victimWay_i][index_i];

  // expand byte enables into a bit mask
  always_comb begin
    for (int b = 0; b < `DCACHE_WORD_W / 8; b++) begin
      bitMask[b*8 +: 8] = {8{wrMask_i[b]}};
    end
  end

  // untouched lanes keep the old word contents
  assign mergedWord = (wrData_i & bitMask) | (rdWord_o & ~bitMask);

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      dataQ[victimWay_i][index_i] <= fillLine_i;
    end else if (storeEn_i) begin
      dataQ[hitWay_i][index_i][wordSel_i * `DCACHE_WORD_W +: `DCACHE_WORD_W] <= mergedWord;
    end
  end

endmodule

// File: hw/dcacheCtrl.sv
`timescale 1ns/1ps

module dcacheCtrl (
  input  logic clk,
  input  logic rst_n,
  input  logic accepted_i,
  input  logic isWrite_i,
  input  logic hit_i,
  input  logic victimDirty_i,
  input  logic wbDone_i,
  input  logic refillDone_i,
  output logic idle_o,
  output logic rspValid_o,
  output logic storeEn_o,
  output logic markDirty_o,
  output logic missEn_o,
  output logic wbActive_o,
  output logic refillActive_o,
  output logic fillEn_o
);

  dcachePkg::ctrlStateT stateQ;
  dcachePkg::ctrlStateT stateD;
  logic                 lookup;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= dcachePkg::Idle;
    end else begin
      stateQ <= stateD;
    end
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      dcachePkg::Idle: begin
        if (accepted_i) begin
          stateD = dcachePkg::Lookup;
        end
      end
      dcachePkg::Lookup: begin
        if (hit_i) begin
          stateD = dcachePkg::Idle;
        end else if (victimDirty_i) begin
          stateD = dcachePkg::WriteBack;
        end else begin
          stateD = dcachePkg::Refill;
        end
      end
      dcachePkg::WriteBack: begin
        if (wbDone_i) begin
          stateD = dcachePkg::Refill;
        end
      end
      dcachePkg::Refill: begin
        if (refillDone_i) begin
          stateD = dcachePkg::Fill;
        end
      end
      // one cycle to install the line, then look up again
      dcachePkg::Fill: stateD = dcachePkg::Lookup;
      default: stateD = dcachePkg::Idle;
    endcase
  end

  assign lookup = (stateQ == dcachePkg::Lookup);

  assign idle_o         = (stateQ == dcachePkg::Idle);
  assign rspValid_o     = lookup && hit_i;
  assign storeEn_o      = rspValid_o && isWrite_i;
  assign markDirty_o    = storeEn_o;
  assign missEn_o       = lookup && !hit_i;
  assign wbActive_o     = (stateQ == dcachePkg::WriteBack);
  assign refillActive_o = (stateQ == dcachePkg::Refill);
  assign fillEn_o       = (stateQ == dcachePkg::Fill);

  // the lookup after a fill finds the installed line and responds
  rspAfterFill: assert property (@(posedge clk) disable iff (!rst_n)
    fillEn_o |=> rspValid_o);

endmodule

// File: hw/dcacheMemPort.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcacheMemPort (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wbActive_i,
  input  logic             refillActive_i,
  input  dcachePkg::tagT   tag_i,
  input  dcachePkg::indexT index_i,
  input  dcachePkg::tagT   victimTag_i,
  input  dcachePkg::lineT  victimLine_i,
  input  logic             memWrGnt_i,
  input  logic             memRdGnt_i,
  input  logic             memRdValid_i,
  input  dcachePkg::wordT  memRdData_i,
  input  logic             memRdLast_i,
  output logic             memWrReq_o,
  output dcachePkg::addrT  memWrAddr_o,
  output dcachePkg::lineT  memWrLine_o,
  output logic             wbDone_o,
  output logic             memRdReq_o,
  output dcachePkg::addrT  memRdAddr_o,
  output logic             refillDone_o,
  output dcachePkg::lineT  fillLine_o
);

  logic               rdGrantedQ;
  dcachePkg::wordSelT beatCntQ;
  dcachePkg::lineT    refillBufQ;
  logic               beatValid;

  // write-back is a single transfer held for the whole WriteBack state
  assign memWrReq_o  = wbActive_i;
  assign memWrAddr_o = {victimTag_i, index_i, {`DCACHE_OFFSET_W{1'b0}}};
  assign memWrLine_o = victimLine_i;
  assign wbDone_o    = wbActive_i && memWrGnt_i;

  // read request drops once granted, beats follow
  assign memRdReq_o   = refillActive_i && !rdGrantedQ;
  assign memRdAddr_o  = {tag_i, index_i, {`DCACHE_OFFSET_W{1'b0}}};
  assign beatValid    = refillActive_i && rdGrantedQ && memRdValid_i;
  assign refillDone_o = beatValid && memRdLast_i;
  assign fillLine_o   = refillBufQ;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdGrantedQ <= 1'b0;
      beatCntQ   <= '0;
    end else if (memRdReq_o && memRdGnt_i) begin
      rdGrantedQ <= 1'b1;
      beatCntQ   <= '0;
    end else if (beatValid) begin
      beatCntQ <= beatCntQ + 1'b1;
      if (memRdLast_i) begin
        rdGrantedQ <= 1'b0;
      end
    end
  end

  // beats arrive in ascending word order
  always_ff @(posedge clk) begin
    if (beatValid) begin
      refillBufQ[beatCntQ * `DCACHE_WORD_W +: `DCACHE_WORD_W] <= memRdData_i;
    end
  end

  onlyOneMemReq: assert property (@(posedge clk) disable iff (!rst_n)
    !(memWrReq_o && memRdReq_o));

  lastOnFinalBeat: assert property (@(posedge clk) disable iff (!rst_n)
    beatValid |-> (memRdLast_i == (beatCntQ == dcachePkg::wordSelT'(`DCACHE_BEATS - 1))));

endmodule

// File: hw/dcacheTop.sv
`timescale 1ns/1ps

module dcacheTop (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            reqValid_i,
  input  logic            reqWrite_i,
  input  dcachePkg::addrT reqAddr_i,
  input  dcachePkg::wordT reqWrData_i,
  input  dcachePkg::maskT reqWrMask_i,
  output logic            reqReady_o,
  output logic            rspValid_o,
  output dcachePkg::wordT rspRdData_o,
  output logic            memWrReq_o,
  output dcachePkg::addrT memWrAddr_o,
  output dcachePkg::lineT memWrLine_o,
  input  logic            memWrGnt_i,
  output logic            memRdReq_o,
  output dcachePkg::addrT memRdAddr_o,
  input  logic            memRdGnt_i,
  input  logic            memRdValid_i,
  input  dcachePkg::wordT memRdData_i,
  input  logic            memRdLast_i
);

  // request fields held by the capture block
  logic               accepted;
  logic               isWrite;
  dcachePkg::tagT     reqTag;
  dcachePkg::indexT   reqIndex;
  dcachePkg::wordSelT wordSel;
  dcachePkg::wordT    wrData;
  dcachePkg::maskT    wrMask;

  // controller strobes
  logic idle;
  logic storeEn;
  logic markDirty;
  logic missEn;
  logic wbActive;
  logic refillActive;
  logic fillEn;

  // lookup results and line movement
  logic            hit;
  dcachePkg::wayT  hitWay;
  dcachePkg::wayT  victimWay;
  logic            victimDirty;
  dcachePkg::tagT  victimTag;
  dcachePkg::lineT victimLine;
  dcachePkg::lineT fillLine;
  logic            wbDone;
  logic            refillDone;

  dcacheReqCapture reqCapture_i (
    .clk, .rst_n, .reqValid_i, .reqWrite_i, .reqAddr_i, .reqWrData_i, .reqWrMask_i,
    .idle_i(idle), .reqReady_o, .accepted_o(accepted), .isWrite_o(isWrite),
    .tag_o(reqTag), .index_o(reqIndex), .wordSel_o(wordSel),
    .wrData_o(wrData), .wrMask_o(wrMask)
  );

  dcacheCtrl ctrl_i (
    .clk, .rst_n, .accepted_i(accepted), .isWrite_i(isWrite), .hit_i(hit),
    .victimDirty_i(victimDirty), .wbDone_i(wbDone), .refillDone_i(refillDone),
    .idle_o(idle), .rspValid_o, .storeEn_o(storeEn), .markDirty_o(markDirty),
    .missEn_o(missEn), .wbActive_o(wbActive), .refillActive_o(refillActive),
    .fillEn_o(fillEn)
  );

  dcacheTagStore tagStore_i (
    .clk, .rst_n, .index_i(reqIndex), .tag_i(reqTag), .missEn_i(missEn),
    .markDirty_i(markDirty), .fillEn_i(fillEn), .hit_o(hit), .hitWay_o(hitWay),
    .victimWay_o(victimWay), .victimDirty_o(victimDirty), .victimTag_o(victimTag)
  );

  dcacheDataStore dataStore_i (
    .clk, .index_i(reqIndex), .wordSel_i(wordSel), .hitWay_i(hitWay),
    .victimWay_i(victimWay), .storeEn_i(storeEn), .wrData_i(wrData),
    .wrMask_i(wrMask), .fillEn_i(fillEn), .fillLine_i(fillLine),
    .rdWord_o(rspRdData_o), .victimLine_o(victimLine)
  );

  dcacheMemPort memPort_i (
    .clk, .rst_n, .wbActive_i(wbActive), .refillActive_i(refillActive),
    .tag_i(reqTag), .index_i(reqIndex), .victimTag_i(victimTag),
    .victimLine_i(victimLine), .memWrGnt_i, .memRdGnt_i, .memRdValid_i,
    .memRdData_i, .memRdLast_i, .memWrReq_o, .memWrAddr_o, .memWrLine_o,
    .wbDone_o(wbDone), .memRdReq_o, .memRdAddr_o, .refillDone_o(refillDone),
    .fillLine_o(fillLine)
  );

endmodule

// File: bench/dcacheMemModel.sv
`timescale 1ns/1ps

module dcacheMemModel (
  input  logic            clk,
  input  logic            wrReq_i,
  input  dcachePkg::addrT wrAddr_i,
  input  dcachePkg::lineT wrLine_i,
  output logic            wrGnt_o,
  input  logic            rdReq_i,
  input  dcachePkg::addrT rdAddr_i,
  output logic            rdGnt_o,
  output logic            rdValid_o,
  output dcachePkg::wordT rdData_o,
  output logic            rdLast_o
);

  // words keyed by byte address, words never written keep their initial pattern
  dcachePkg::wordT mem [dcachePkg::addrT];

  function automatic dcachePkg::wordT initWord(input dcachePkg::addrT a);
    return {a ^ 32'h5ac3_e10f, ~a + 32'h0101_0101};
  endfunction

  function automatic dcachePkg::wordT readWord(input dcachePkg::addrT a);
    return mem.exists(a) ? mem[a] : initWord(a);
  endfunction

  // write-back: grant after 0-3 cycles, line is taken on the grant edge
  initial begin
    wrGnt_o = 1'b0;
    forever begin
      @(negedge clk);
      if (wrReq_i) begin
        repeat ($urandom_range(3, 0)) @(negedge clk);
        for (int b = 0; b < 4; b++) begin
          mem[wrAddr_i + 32'(8 * b)] = wrLine_i[b*64 +: 64];
        end
        wrGnt_o = 1'b1;
        @(negedge clk);
        wrGnt_o = 1'b0;
      end
    end
  end

  // refill: delayed grant, then four ascending beats with random gaps
  initial begin
    dcachePkg::addrT base;
    rdGnt_o   = 1'b0;
    rdValid_o = 1'b0;
    rdData_o  = '0;
    rdLast_o  = 1'b0;
    forever begin
      @(negedge clk);
      if (rdReq_i) begin
        base = rdAddr_i;
        repeat ($urandom_range(3, 0)) @(negedge clk);
        rdGnt_o = 1'b1;
        @(negedge clk);
        rdGnt_o = 1'b0;
        for (int b = 0; b < 4; b++) begin
          repeat ($urandom_range(3, 0)) @(negedge clk);
          rdValid_o = 1'b1;
          rdData_o  = readWord(base + 32'(8 * b));
          rdLast_o  = (b == 3);
          @(negedge clk);
          rdValid_o = 1'b0;
          rdLast_o  = 1'b0;
        end
      end
    end
  end

endmodule

// File: bench/dcacheTb.sv
`timescale 1ns/1ps

module dcacheTb;

  // about 320 requests of 40 cycles or fewer each, plus margin
  localparam int maxCycles = 20000;

  logic            clk;
  logic            rst_n;
  logic            reqValid_i;
  logic            reqWrite_i;
  dcachePkg::addrT reqAddr_i;
  dcachePkg::wordT reqWrData_i;
  logic [7:0]      reqWrMask_i;
  logic            reqReady_o;
  logic            rspValid_o;
  dcachePkg::wordT rspRdData_o;
  logic            memWrReq_o;
  dcachePkg::addrT memWrAddr_o;
  dcachePkg::lineT memWrLine_o;
  logic            memWrGnt_i;
  logic            memRdReq_o;
  dcachePkg::addrT memRdAddr_o;
  logic            memRdGnt_i;
  logic            memRdValid_i;
  dcachePkg::wordT memRdData_i;
  logic            memRdLast_i;

  // reference state: shadow memory plus a model of tags, dirty bits and victim pointer
  dcachePkg::wordT shadow [dcachePkg::addrT];
  dcachePkg::addrT cachedLine [2][64];
  bit              cachedValid [2][64];
  bit              cachedDirty [2][64];
  bit              nextVictim;

  // expectations handed from the stimulus to the compare process
  dcachePkg::wordT expData[$];
  bit              expIsLoad[$];
  dcachePkg::addrT wbAddrQ[$];
  dcachePkg::lineT wbLineQ[$];
  dcachePkg::addrT rfAddrQ[$];
  dcachePkg::wordT expWord;
  bit              expLoad;
  dcachePkg::addrT expAddr;
  dcachePkg::lineT expLine;

  int errors;
  int testsRun;
  int testsFailed;
  int rdCount;
  int wrCount;
  int wbPredicted;
  int latency;
  int cycles;

  dcacheTop dcacheTop_i (.*);

  dcacheMemModel memModel_i (
    .clk, .wrReq_i(memWrReq_o), .wrAddr_i(memWrAddr_o), .wrLine_i(memWrLine_o),
    .wrGnt_o(memWrGnt_i), .rdReq_i(memRdReq_o), .rdAddr_i(memRdAddr_o),
    .rdGnt_o(memRdGnt_i), .rdValid_o(memRdValid_i), .rdData_o(memRdData_i),
    .rdLast_o(memRdLast_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= maxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", maxCycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic dcachePkg::wordT initWord(input dcachePkg::addrT a);
    return {a ^ 32'h5ac3_e10f, ~a + 32'h0101_0101};
  endfunction

  function automatic dcachePkg::wordT shadowWord(input dcachePkg::addrT a);
    return shadow.exists(a) ? shadow[a] : initWord(a);
  endfunction

  // 32-byte lines, index in address bits 10..5
  function automatic dcachePkg::addrT lineOf(input int tag, input int set);
    return dcachePkg::addrT'((tag << 11) | (set << 5));
  endfunction

  // applies one request to the reference and returns the expected load word
  function automatic dcachePkg::wordT refAccess(input bit write, input dcachePkg::addrT addr,
      input dcachePkg::wordT data, input logic [7:0] mask);
    dcachePkg::addrT lineAddr;
    dcachePkg::addrT wordAddr;
    dcachePkg::lineT line;
    dcachePkg::wordT merged;
    int idx;
    int way;
    lineAddr = {addr[31:5], 5'b0};
    wordAddr = {addr[31:3], 3'b0};
    idx = int'(addr[10:5]);
    way = -1;
    for (int w = 0; w < 2; w++) begin
      if (cachedValid[w][idx] && cachedLine[w][idx] == lineAddr) begin
        way = w;
      end
    end
    if (way < 0) begin
      way = int'(nextVictim);
      // a dirty victim leaves as the current shadow contents of its line
      if (cachedValid[way][idx] && cachedDirty[way][idx]) begin
        for (int b = 0; b < 4; b++) begin
          line[b*64 +: 64] = shadowWord(cachedLine[way][idx] + 32'(8 * b));
        end
        wbAddrQ.push_back(cachedLine[way][idx]);
        wbLineQ.push_back(line);
        wbPredicted++;
      end
      rfAddrQ.push_back(lineAddr);
      cachedValid[way][idx] = 1'b1;
      cachedDirty[way][idx] = 1'b0;
      cachedLine[way][idx]  = lineAddr;
      nextVictim = ~nextVictim;
    end
    if (write) begin
      merged = shadowWord(wordAddr);
      for (int b = 0; b < 8; b++) begin
        if (mask[b]) begin
          merged[b*8 +: 8] = data[b*8 +: 8];
        end
      end
      shadow[wordAddr] = merged;
      cachedDirty[way][idx] = 1'b1;
    end
    return shadowWord(wordAddr);
  endfunction

  // compare process, samples the values present at each rising edge
  always @(posedge clk) begin
    if (rst_n && rspValid_o) begin
      assert (expData.size() > 0) else begin
        $display("Response at %0t with no request in flight", $time);
        errors++;
      end
      if (expData.size() > 0) begin
        expWord = expData.pop_front();
        expLoad = expIsLoad.pop_front();
        assert (!expLoad || rspRdData_o == expWord) else begin
          $display("Mismatch at %0t: load returned %h, expected %h", $time, rspRdData_o, expWord);
          errors++;
        end
      end
    end
    if (rst_n && memWrReq_o && memWrGnt_i) begin
      wrCount++;
      assert (wbAddrQ.size() > 0) else begin
        $display("Write-back at %0t that the reference did not predict", $time);
        errors++;
      end
      if (wbAddrQ.size() > 0) begin
        expAddr = wbAddrQ.pop_front();
        expLine = wbLineQ.pop_front();
        assert (memWrAddr_o == expAddr && memWrLine_o == expLine) else begin
          $display("Mismatch at %0t: write-back to %h, expected a line at %h",
                   $time, memWrAddr_o, expAddr);
          errors++;
        end
      end
    end
    if (rst_n && memRdReq_o && memRdGnt_i) begin
      rdCount++;
      assert (rfAddrQ.size() > 0) else begin
        $display("Refill at %0t that the reference did not predict", $time);
        errors++;
      end
      if (rfAddrQ.size() > 0) begin
        expAddr = rfAddrQ.pop_front();
        assert (memRdAddr_o == expAddr) else begin
          $display("Mismatch at %0t: refill from %h, expected %h", $time, memRdAddr_o, expAddr);
          errors++;
        end
      end
    end
  end

  task automatic requireNotReady();
    assert (!reqReady_o) else begin
      $display("reqReady_o was high at %0t while a request was in flight", $time);
      errors++;
    end
  endtask

  // one request, called on a falling edge, returns one cycle after the response
  task automatic accessCache(input bit write, input dcachePkg::addrT addr,
      input dcachePkg::wordT data, input logic [7:0] mask);
    while (!reqReady_o) begin
      @(negedge clk);
    end
    expData.push_back(refAccess(write, addr, data, mask));
    expIsLoad.push_back(!write);
    reqValid_i  = 1'b1;
    reqWrite_i  = write;
    reqAddr_i   = addr;
    reqWrData_i = data;
    reqWrMask_i = mask;
    @(negedge clk);
    reqValid_i = 1'b0;
    latency = 1;
    requireNotReady();
    while (!rspValid_o) begin
      @(negedge clk);
      latency++;
      requireNotReady();
    end
    @(negedge clk);
  endtask

  task automatic checkTrue(input bit cond, input string what);
    assert (cond) else begin
      $display("Check failed at %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    testsRun++;
    if (errors == errorsBefore) begin
      $display("test %s: passed", name);
    end else begin
      testsFailed++;
      $display("test %s: failed with %0d errors", name, errors - errorsBefore);
    end
  endtask

  initial begin
    int errBefore;
    int rdBefore;
    int wrBefore;
    int wbBefore;
    void'($urandom(32'h1e4d79d5));
    rst_n       = 1'b0;
    reqValid_i  = 1'b0;
    reqWrite_i  = 1'b0;
    reqAddr_i   = '0;
    reqWrData_i = '0;
    reqWrMask_i = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    errBefore = errors;
    checkTrue(reqReady_o && !rspValid_o && !memRdReq_o && !memWrReq_o,
              "outputs not in their idle state after reset");
    accessCache(1'b0, lineOf(3, 1), '0, '0);
    accessCache(1'b0, lineOf(3, 1) + 8, '0, '0);
    checkTrue(latency == 1, "load hit did not respond one cycle after acceptance");
    checkTrue(!rspValid_o, "rspValid_o stayed high for more than one cycle");
    finishTest("reset and load hit", errBefore);

    errBefore = errors;
    rdBefore = rdCount;
    accessCache(1'b0, lineOf(5, 2) + 16, '0, '0);
    checkTrue(rdCount == rdBefore + 1, "load miss did not issue exactly one refill");
    accessCache(1'b0, lineOf(5, 2) + 24, '0, '0);
    checkTrue(rdCount == rdBefore + 1 && latency == 1, "second load to a line went to memory");
    finishTest("load miss and refill", errBefore);

    errBefore = errors;
    accessCache(1'b1, lineOf(5, 2) + 16, 64'h1122_3344_5566_7788, 8'b1010_0110);
    accessCache(1'b0, lineOf(5, 2) + 16, '0, '0);
    accessCache(1'b1, lineOf(6, 3) + 8, 64'h99aa_bbcc_ddee_ff00, 8'b1100_0011);
    accessCache(1'b0, lineOf(6, 3) + 8, '0, '0);
    finishTest("partial store merge", errBefore);

    // two clean fills, dirty the first, then two more lines in the same set
    errBefore = errors;
    wrBefore = wrCount;
    accessCache(1'b0, lineOf(17, 10), '0, '0);
    accessCache(1'b0, lineOf(18, 10) + 8, '0, '0);
    accessCache(1'b1, lineOf(17, 10) + 16, 64'hfeed_face_cafe_beef, 8'hf0);
    accessCache(1'b0, lineOf(19, 10), '0, '0);
    checkTrue(wrCount == wrBefore + 1, "dirty victim did not cause exactly one write-back");
    accessCache(1'b0, lineOf(20, 10), '0, '0);
    checkTrue(wrCount == wrBefore + 1, "clean victim caused a write-back");
    accessCache(1'b0, lineOf(17, 10) + 16, '0, '0);
    finishTest("eviction and write-back", errBefore);

    // random traffic over sets 48..51 and tags 64..69
    errBefore = errors;
    wrBefore = wrCount;
    wbBefore = wbPredicted;
    for (int n = 0; n < 300; n++) begin
      accessCache($urandom_range(1, 0) == 1,
                  lineOf(64 + int'($urandom_range(5, 0)), 48 + int'($urandom_range(3, 0)))
                    + 32'(8 * $urandom_range(3, 0)),
                  {$urandom, $urandom}, 8'($urandom));
    end
    checkTrue(wrCount - wrBefore == wbPredicted - wbBefore,
              "write-back count differs from the reference");
    checkTrue(wbAddrQ.size() == 0 && rfAddrQ.size() == 0 && expData.size() == 0,
              "predicted transfers never happened");
    finishTest("random loads and stores", errBefore);

    $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (testsFailed == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: dcacheTop.f
+incdir+hw
hw/dcachePkg.sv
hw/dcacheReqCapture.sv
hw/dcacheTagStore.sv
hw/dcacheDataStore.sv
hw/dcacheCtrl.sv
hw/dcacheMemPort.sv
hw/dcacheTop.sv
bench/dcacheMemModel.sv
bench/dcacheTb.sv

// File: run.sh
#!/bin/sh
# compile the cache and its testbench with Verilator, then run the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dcacheTb -f dcacheTop.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/VdcacheTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
